// ==== verilog.f ====
+incdir+hdl
hdl/rvIsaPkg.sv
hdl/uopPkg.sv
hdl/uopIf.sv
hdl/immGen.sv
hdl/instrDecoder.sv
hdl/fetchSplitter.sv
hdl/decodeCollector.sv
hdl/decodeStage.sv
testbench/tbClock.sv
testbench/decodeStageTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary -f verilog.f --top-module decodeStageTb -o simDecodeStage

out=$(./obj_dir/simDecodeStage)
echo "$out"

if grep -q "PASS: all tests" <<< "$out"; then
    exit 0
else
    exit 1
fi

// ==== testbench/decodeStageTb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "decode_cfg.svh"

module decodeStageTb import rvIsaPkg::*; ();

    typedef struct packed {
        logic [63:0] imm;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [4:0]  rd;
        logic        aluASrc;
        logic [1:0]  aluBSrc;
        logic [5:0]  aluCtrl;
        logic [2:0]  branch;
        logic        memRead;
        logic        memWrite;
        logic [2:0]  memOp;
        logic        memToReg;
        logic        regWrite;
        logic        illegal;
        logic        halt;
    } uopExp_t;

    localparam instr_t NOP = 32'h00000013;

    logic                      clock;
    logic                      reset;
    logic                      packetValid;
    logic                      packetReady;
    instr_t [`DEC_LANES-1:0]   packet;
    logic                      uopValid;
    logic                      uopReady;
    logic [63:0]               imm;
    logic [4:0]                rs1;
    logic [4:0]                rs2;
    logic [4:0]                rd;
    logic                      aluASrc;
    logic [1:0]                aluBSrc;
    logic [5:0]                aluCtrl;
    logic [2:0]                branch;
    logic                      memRead;
    logic                      memWrite;
    logic [2:0]                memOp;
    logic                      memToReg;
    logic                      regWrite;
    logic                      illegal;
    logic                      halt;

    integer seed = 32'h078d1cec;
    int     errors = 0;
    int     checks = 0;
    int     sentCount = 0;
    int     recvCount = 0;
    int     cycles = 0;
    int     readyPct = 100;
    instr_t expQ[$];   // accepted, not yet seen at the output
    instr_t sendQ[$];

    tbClock clockGen (.clock(clock));

    decodeStage uut (
        .clock(clock), .reset(reset),
        .packetValid(packetValid), .packetReady(packetReady), .packet(packet),
        .uopValid(uopValid), .uopReady(uopReady), .imm(imm),
        .rs1(rs1), .rs2(rs2), .rd(rd), .aluASrc(aluASrc), .aluBSrc(aluBSrc),
        .aluCtrl(aluCtrl), .branch(branch), .memRead(memRead), .memWrite(memWrite),
        .memOp(memOp), .memToReg(memToReg), .regWrite(regWrite),
        .illegal(illegal), .halt(halt)
    );

    function automatic instr_t encI(int v, int s1, int f3, int d, logic [6:0] op);
        return {v[11:0], s1[4:0], f3[2:0], d[4:0], op};
    endfunction

    function automatic instr_t encS(int v, int s2, int s1, int f3);
        return {v[11:5], s2[4:0], s1[4:0], f3[2:0], v[4:0], 7'b0100011};
    endfunction

    function automatic instr_t encB(int v, int s2, int s1, int f3);
        return {v[12], v[10:5], s2[4:0], s1[4:0], f3[2:0], v[4:1], v[11], 7'b1100011};
    endfunction

    function automatic instr_t encJ(int v, int d);
        return {v[20], v[10:1], v[11], v[19:12], d[4:0], 7'b1101111};
    endfunction

    function automatic instr_t encU(int v, int d, logic [6:0] op);
        return {v[31:12], d[4:0], op};
    endfunction

    function automatic instr_t encR(logic [6:0] f7, int s2, int s1, int f3, int d,
                                    logic [6:0] op);
        return {f7, s2[4:0], s1[4:0], f3[2:0], d[4:0], op};
    endfunction

    function automatic logic [63:0] ext(int v);
        return {{32{v[31]}}, v};
    endfunction

    // expected micro-op from the RV64I/M decode rules
    function automatic uopExp_t refDecode(instr_t i);
        uopExp_t e;
        logic [2:0] f3;
        logic [6:0] f7;
        logic [4:0] op;
        f3 = i[14:12];
        f7 = i[31:25];
        op = i[6:2];
        e = '0;
        e.rs1 = i[19:15];
        e.rs2 = i[24:20];
        e.rd = i[11:7];
        e.memOp = f3;
        e.memRead = op == LOAD;
        e.memToReg = op == LOAD;
        e.memWrite = op == STORE;
        e.regWrite = op != BRANCH && op != STORE;
        e.aluASrc = op == AUIPC || op == JAL || op == JALR;
        e.halt = i == 32'h00100073;
        case (op)
            LUI, AUIPC: e.imm = {{32{i[31]}}, i[31:12], 12'b0};
            JAL:        e.imm = {{44{i[31]}}, i[19:12], i[20], i[30:21], 1'b0};
            BRANCH:     e.imm = {{52{i[31]}}, i[7], i[30:25], i[11:8], 1'b0};
            STORE:      e.imm = {{52{i[31]}}, i[31:25], i[11:7]};
            default:    e.imm = {{52{i[31]}}, i[31:20]};
        endcase
        case (op)
            LUI, AUIPC, LOAD, STORE, OPIMM, OPIMM32: e.aluBSrc = 2'd2;
            JAL, JALR, SYSTEM:                       e.aluBSrc = 2'd1;
            default:                                 e.aluBSrc = 2'd0;
        endcase
        e.aluCtrl[5] = op == OP32 || (op == OP && f7 == 7'h01);
        e.aluCtrl[4] = i[3];
        case (op)
            LUI:            e.aluCtrl[3:0] = 4'b1111;
            BRANCH:         e.aluCtrl[3:0] = f3[1] ? 4'b0011 : 4'b0010;
            OPIMM, OPIMM32: e.aluCtrl[3:0] = {f7[5] && f3 == 3'b101, f3};
            OP, OP32:       e.aluCtrl[3:0] = {f7[5], f3};
            default:        e.aluCtrl[3:0] = 4'b0000;
        endcase
        case (op)
            JAL, SYSTEM: e.branch = 3'b001;
            JALR:        e.branch = 3'b010;
            BRANCH:      e.branch = {1'b1, f3[2] ? {1'b1, f3[0]} : {1'b0, f3[0]}};
            default:     e.branch = 3'b000;
        endcase
        case (op)
            LUI, AUIPC, JAL: e.illegal = 1'b0;
            JALR:    e.illegal = f3 != 3'b000;
            BRANCH:  e.illegal = f3 == 3'b010 || f3 == 3'b011;
            LOAD:    e.illegal = f3 == 3'b111;
            STORE:   e.illegal = f3[2];
            OPIMM:   e.illegal = (f3 == 3'b001 && f7[6:1] != 6'b000000)
                              || (f3 == 3'b101 && f7[6:1] != 6'b000000
                                               && f7[6:1] != 6'b010000);
            OPIMM32: e.illegal = !(f3 == 3'b000 || (f3 == 3'b001 && f7 == 7'h00)
                                || (f3 == 3'b101 && (f7 == 7'h00 || f7 == 7'h20)));
            OP:      e.illegal = f7 != 7'h00 && f7 != 7'h20 && f7 != 7'h01;
            OP32:    e.illegal = !((f7 == 7'h00 && (f3 == 3'd0 || f3 == 3'd1 || f3 == 3'd5))
                                || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5))
                                || (f7 == 7'h01 && f3 != 3'd1 && f3 != 3'd2 && f3 != 3'd3));
            SYSTEM:  e.illegal = !e.halt;
            default: e.illegal = 1'b1;
        endcase
        if (i[1:0] != 2'b11) begin
            e.illegal = 1'b1;
        end
        return e;
    endfunction

    task automatic checkValue(string name, logic [63:0] expected, logic [63:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("Error at %0t: %s expected %h got %h", $time, name, expected, actual);
        end
    endtask

    task automatic compareUop(uopExp_t e);
        checkValue("illegal", 64'(e.illegal), 64'(illegal));
        checkValue("halt", 64'(e.halt), 64'(halt));
        if (!e.illegal) begin  // other fields are don't-care for illegal ops
            checkValue("imm", e.imm, imm);
            checkValue("rs1", 64'(e.rs1), 64'(rs1));
            checkValue("rs2", 64'(e.rs2), 64'(rs2));
            checkValue("rd", 64'(e.rd), 64'(rd));
            checkValue("aluASrc", 64'(e.aluASrc), 64'(aluASrc));
            checkValue("aluBSrc", 64'(e.aluBSrc), 64'(aluBSrc));
            checkValue("aluCtrl", 64'(e.aluCtrl), 64'(aluCtrl));
            checkValue("branch", 64'(e.branch), 64'(branch));
            checkValue("memRead", 64'(e.memRead), 64'(memRead));
            checkValue("memWrite", 64'(e.memWrite), 64'(memWrite));
            checkValue("memOp", 64'(e.memOp), 64'(memOp));
            checkValue("memToReg", 64'(e.memToReg), 64'(memToReg));
            checkValue("regWrite", 64'(e.regWrite), 64'(regWrite));
        end
    endtask

    // transfer happens at the next rising edge
    always begin
        @(negedge clock);
        uopReady = ({$random(seed)} % 100) < readyPct;
        #1;
        if (!reset && uopValid && uopReady) begin
            if (expQ.size() == 0) begin
                errors++;
                $display("micro-op came out with no instruction outstanding at %0t", $time);
            end else begin
                compareUop(refDecode(expQ.pop_front()));
            end
            recvCount++;
        end
    end

    always @(posedge clock) begin
        cycles++;
        if (cycles > 40 * sentCount + 200) begin
            $display("timeout: stage made no progress, %0d cycles, %0d sent, %0d received",
                     cycles, sentCount, recvCount);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    // pushes sendQ as full packets, padded with nops
    task automatic sendAll();
        while (sendQ.size() > 0) begin
            @(negedge clock);
            for (int l = 0; l < `DEC_LANES; l++) begin
                packet[l] = (sendQ.size() > 0) ? sendQ.pop_front() : NOP;
            end
            packetValid = 1'b1;
            #1;
            while (!packetReady) begin
                @(negedge clock);
                #1;
            end
            for (int l = 0; l < `DEC_LANES; l++) begin
                expQ.push_back(packet[l]);
            end
            sentCount += `DEC_LANES;
        end
        @(negedge clock);
        packetValid = 1'b0;
    endtask

    task automatic waitDrain();
        while (expQ.size() != 0) begin
            @(negedge clock);
        end
        repeat (4) @(negedge clock);
    endtask

    task automatic makeLegal(output instr_t i);
        logic [31:0] r;
        logic [31:0] s;
        logic [2:0]  f3;
        r = $random(seed);
        s = $random(seed);
        f3 = r[14:12];
        case ({s} % 10)
            0: i = encU(r, r[11:7], 7'b0110111);
            1: i = encU(r, r[11:7], 7'b0010111);
            2: i = encJ(r, r[11:7]);
            3: i = encI(r, r[19:15], 0, r[11:7], 7'b1100111);
            4: i = encB(r, r[24:20], r[19:15], f3[2:1] == 2'b01 ? {1'b1, f3[1:0]} : f3);
            5: i = encI(r, r[19:15], f3 == 3'b111 ? 3 : f3, r[11:7], 7'b0000011);
            6: i = encS(r, r[24:20], r[19:15], f3[1:0]);
            7: begin
                i = {r[31:15], f3, r[11:7], 7'b0010011};
                if (f3 == 3'b001) i[31:26] = 6'b000000;
                if (f3 == 3'b101) i[31:26] = {1'b0, s[8], 4'b0000};
            end
            8: i = encR(s[5:4] == 2'd0 ? 7'h20 : (s[5:4] == 2'd1 ? 7'h01 : 7'h00),
                        r[24:20], r[19:15], f3, r[11:7], 7'b0110011);
            default: begin
                case (f3)
                    3'd0: i = encR(7'h00, r[24:20], r[19:15], 0, r[11:7], 7'b0111011);
                    3'd1: i = encR(7'h20, r[24:20], r[19:15], 0, r[11:7], 7'b0111011);
                    3'd2: i = encR(7'h00, r[24:20], r[19:15], 1, r[11:7], 7'b0111011);
                    3'd3: i = encR(7'h00, r[24:20], r[19:15], 5, r[11:7], 7'b0111011);
                    3'd4: i = encR(7'h20, r[24:20], r[19:15], 5, r[11:7], 7'b0111011);
                    3'd5: i = encR(7'h01, r[24:20], r[19:15], 0, r[11:7], 7'b0111011);
                    3'd6: i = encR(7'h01, r[24:20], r[19:15], 4, r[11:7], 7'b0111011);
                    default: i = encR(7'h01, r[24:20], r[19:15], 7, r[11:7], 7'b0111011);
                endcase
            end
        endcase
    endtask

    task automatic testReset();
        @(negedge clock);
        #1;
        checkValue("uopValid", 64'd0, 64'(uopValid));
        checkValue("packetReady", 64'd1, 64'(packetReady));
    endtask

    task automatic testImmediates();
        instr_t  list[$];
        int      vals[$];
        uopExp_t e;
        list = '{encI(-5, 2, 0, 1, 7'b0010011), encI(2047, 3, 0, 4, 7'b0010011),
                 encS(-8, 5, 6, 3), encS(100, 7, 8, 3), encB(-16, 1, 2, 0),
                 encB(64, 3, 4, 0), encJ(-4, 1), encJ(32'h800, 1),
                 encU(32'h80000000, 9, 7'b0110111), encU(32'h12345000, 9, 7'b0110111)};
        vals = '{-5, 2047, -8, 100, -16, 64, -4, 32'h800, 32'h80000000, 32'h12345000};
        foreach (list[k]) begin
            e = refDecode(list[k]);
            checkValue("reference imm", ext(vals[k]), e.imm);
            sendQ.push_back(list[k]);
        end
        sendAll();
        waitDrain();
    endtask

    task automatic testControl();
        sendQ = '{encU(32'h12345000, 3, 7'b0110111), encU(32'hfff00000, 4, 7'b0010111),
                  encJ(256, 1), encI(12, 5, 0, 1, 7'b1100111), encB(-8, 6, 7, 0),
                  encB(20, 8, 9, 6), encI(-16, 10, 3, 11, 7'b0000011), encS(24, 12, 2, 3),
                  encI(42, 13, 0, 14, 7'b0010011), encR(7'h20, 3, 15, 5, 16, 7'b0010011),
                  encR(7'h00, 17, 18, 0, 19, 7'b0111011),
                  encR(7'h01, 20, 21, 0, 22, 7'b0110011)};
        sendAll();
        waitDrain();
    endtask

    task automatic testIllegal();
        sendQ = '{NOP ^ 32'h1, 32'h0000000b, encB(8, 1, 2, 2),
                  encI(0, 1, 7, 2, 7'b0000011), encR(7'h02, 1, 2, 0, 3, 7'b0110011),
                  encR(7'h00, 1, 2, 2, 3, 7'b0111011), 32'h00100073};
        sendAll();
        waitDrain();
    endtask

    task automatic testBackpressure();
        instr_t i;
        int     startSent;
        int     startRecv;
        startSent = sentCount;
        startRecv = recvCount;
        readyPct = 60;
        repeat (200) begin
            makeLegal(i);
            sendQ.push_back(i);
        end
        sendAll();
        waitDrain();
        checkValue("received count", 64'(sentCount - startSent), 64'(recvCount - startRecv));
    endtask

    task automatic testThroughput();
        instr_t i;
        int     startSent;
        int     startRecv;
        startSent = sentCount;
        startRecv = recvCount;
        readyPct = 100;
        repeat (20 * `DEC_LANES) begin
            makeLegal(i);
            sendQ.push_back(i);
        end
        sendAll();
        waitDrain();
        checkValue("received count", 64'(sentCount - startSent), 64'(recvCount - startRecv));
    endtask

    initial begin
        reset = 1'b1;
        packetValid = 1'b0;
        packet = '0;
        uopReady = 1'b0;
        repeat (10) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;
        testReset();
        testImmediates();
        testControl();
        testIllegal();
        testBackpressure();
        testThroughput();
        $display("errors: %0d, checks: %0d, sent: %0d, received: %0d",
                 errors, checks, sentCount, recvCount);
        if (errors == 0 && expQ.size() == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== testbench/tbClock.sv ====
`timescale 1ns/1ps
`default_nettype none

module tbClock (
    output logic clock
);

    initial begin
        clock = 1'b0;
    end

    always #10 clock = ~clock;  // 20 ns period

endmodule

`default_nettype wire

// ==== hdl/decodeStage.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "decode_cfg.svh"

module decodeStage
    import rvIsaPkg::*;
    import uopPkg::*;
(
    input  wire logic                    clock,
    input  wire logic                    reset,
    input  wire logic                    packetValid,
    output logic                         packetReady,
    input  wire instr_t [`DEC_LANES-1:0] packet,  // instruction 0 in the low word
    output logic                         uopValid,
    input  wire logic                    uopReady,
    output imm_t                         imm,
    output regIdx_t                      rs1,
    output regIdx_t                      rs2,
    output regIdx_t                      rd,
    output logic                         aluASrc,
    output aluBSrc_t                     aluBSrc,
    output aluCtrl_t                     aluCtrl,
    output branch_t                      branch,
    output logic                         memRead,
    output logic                         memWrite,
    output memOp_t                       memOp,
    output logic                         memToReg,
    output logic                         regWrite,
    output logic                         illegal,
    output logic                         halt
);

    logic [`DEC_LANES-1:0]   laneValid;
    logic [`DEC_LANES-1:0]   laneReady;
    instr_t [`DEC_LANES-1:0] laneInstr;

    uopIf laneUop [`DEC_LANES] ();

    fetchSplitter splitter (
        .clock       (clock),
        .reset       (reset),
        .packetValid (packetValid),
        .packetReady (packetReady),
        .packet      (packet),
        .laneValid   (laneValid),
        .laneReady   (laneReady),
        .laneInstr   (laneInstr)
    );

    for (genvar g = 0; g < `DEC_LANES; g++) begin : gDecode
        instrDecoder decoder (
            .clock   (clock),
            .reset   (reset),
            .inValid (laneValid[g]),
            .inReady (laneReady[g]),
            .instr   (laneInstr[g]),
            .uop     (laneUop[g])
        );
    end

    decodeCollector collector (
        .clock    (clock),
        .reset    (reset),
        .lanes    (laneUop),
        .uopValid (uopValid),
        .uopReady (uopReady),
        .imm      (imm),
        .rs1      (rs1),
        .rs2      (rs2),
        .rd       (rd),
        .aluASrc  (aluASrc),
        .aluBSrc  (aluBSrc),
        .aluCtrl  (aluCtrl),
        .branch   (branch),
        .memRead  (memRead),
        .memWrite (memWrite),
        .memOp    (memOp),
        .memToReg (memToReg),
        .regWrite (regWrite),
        .illegal  (illegal),
        .halt     (halt)
    );

endmodule

`default_nettype wire

// ==== hdl/decodeCollector.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "decode_cfg.svh"

module decodeCollector
    import rvIsaPkg::*;
    import uopPkg::*;
(
    input  wire logic clock,
    input  wire logic reset,
    uopIf.collector   lanes [`DEC_LANES],
    output logic      uopValid,
    input  wire logic uopReady,
    output imm_t      imm,
    output regIdx_t   rs1,
    output regIdx_t   rs2,
    output regIdx_t   rd,
    output logic      aluASrc,
    output aluBSrc_t  aluBSrc,
    output aluCtrl_t  aluCtrl,
    output branch_t   branch,
    output logic      memRead,
    output logic      memWrite,
    output memOp_t    memOp,
    output logic      memToReg,
    output logic      regWrite,
    output logic      illegal,
    output logic      halt
);

    localparam int PtrW = (`DEC_LANES > 1) ? $clog2(`DEC_LANES) : 1;

    logic [PtrW-1:0] ptr;  // lane holding the oldest instruction

    logic     laneValid    [`DEC_LANES];
    imm_t     laneImm      [`DEC_LANES];
    regIdx_t  laneRs1      [`DEC_LANES];
    regIdx_t  laneRs2      [`DEC_LANES];
    regIdx_t  laneRd       [`DEC_LANES];
    logic     laneASrc     [`DEC_LANES];
    aluBSrc_t laneBSrc     [`DEC_LANES];
    aluCtrl_t laneAluCtrl  [`DEC_LANES];
    branch_t  laneBranch   [`DEC_LANES];
    logic     laneMemRead  [`DEC_LANES];
    logic     laneMemWrite [`DEC_LANES];
    memOp_t   laneMemOp    [`DEC_LANES];
    logic     laneMemToReg [`DEC_LANES];
    logic     laneRegWrite [`DEC_LANES];
    logic     laneIllegal  [`DEC_LANES];
    logic     laneHalt     [`DEC_LANES];

    for (genvar g = 0; g < `DEC_LANES; g++) begin : gLane
        assign laneValid[g]    = lanes[g].valid;
        assign laneImm[g]      = lanes[g].imm;
        assign laneRs1[g]      = lanes[g].rs1;
        assign laneRs2[g]      = lanes[g].rs2;
        assign laneRd[g]       = lanes[g].rd;
        assign laneASrc[g]     = lanes[g].aluASrc;
        assign laneBSrc[g]     = lanes[g].aluBSrc;
        assign laneAluCtrl[g]  = lanes[g].aluCtrl;
        assign laneBranch[g]   = lanes[g].branch;
        assign laneMemRead[g]  = lanes[g].memRead;
        assign laneMemWrite[g] = lanes[g].memWrite;
        assign laneMemOp[g]    = lanes[g].memOp;
        assign laneMemToReg[g] = lanes[g].memToReg;
        assign laneRegWrite[g] = lanes[g].regWrite;
        assign laneIllegal[g]  = lanes[g].illegal;
        assign laneHalt[g]     = lanes[g].halt;
        assign lanes[g].ready  = uopReady && ptr == PtrW'(g);  // other lanes stall
    end

    assign uopValid = laneValid[ptr];
    assign imm      = laneImm[ptr];
    assign rs1      = laneRs1[ptr];
    assign rs2      = laneRs2[ptr];
    assign rd       = laneRd[ptr];
    assign aluASrc  = laneASrc[ptr];
    assign aluBSrc  = laneBSrc[ptr];
    assign aluCtrl  = laneAluCtrl[ptr];
    assign branch   = laneBranch[ptr];
    assign memRead  = laneMemRead[ptr];
    assign memWrite = laneMemWrite[ptr];
    assign memOp    = laneMemOp[ptr];
    assign memToReg = laneMemToReg[ptr];
    assign regWrite = laneRegWrite[ptr];
    assign illegal  = laneIllegal[ptr];
    assign halt     = laneHalt[ptr];

    always_ff @(posedge clock) begin
        if (reset) begin
            ptr <= '0;
        end else if (uopValid && uopReady) begin
            ptr <= (ptr == PtrW'(`DEC_LANES - 1)) ? '0 : ptr + 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/fetchSplitter.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "decode_cfg.svh"

module fetchSplitter
    import rvIsaPkg::*;
(
    input  wire logic                    clock,
    input  wire logic                    reset,
    input  wire logic                    packetValid,
    output logic                         packetReady,
    input  wire instr_t [`DEC_LANES-1:0] packet,
    output logic [`DEC_LANES-1:0]        laneValid,
    input  wire logic [`DEC_LANES-1:0]   laneReady,
    output instr_t [`DEC_LANES-1:0]      laneInstr
);

    logic [`DEC_LANES-1:0]   pending;  // lane has not taken its instruction yet
    instr_t [`DEC_LANES-1:0] held;
    logic                    take;

    assign packetReady = ~|pending;
    assign take        = packetValid && packetReady;
    assign laneValid   = pending;
    assign laneInstr   = held;

    always_ff @(posedge clock) begin
        if (reset) begin
            pending <= '0;
        end else if (take) begin
            pending <= '1;
        end else begin
            pending <= pending & ~laneReady;  // each lane clears on its own transfer
        end
    end

    always_ff @(posedge clock) begin
        if (take) begin
            held <= packet;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/instrDecoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module instrDecoder
    import rvIsaPkg::*;
    import uopPkg::*;
(
    input  wire logic   clock,
    input  wire logic   reset,
    input  wire logic   inValid,
    output logic        inReady,
    input  wire instr_t instr,
    uopIf.lane          uop
);

    opcode_e    opcode;
    funct3_t    funct3;
    funct7_t    funct7;
    immFmt_e    fmt;
    imm_t       immVal;
    aluBSrc_t   bSrc;
    logic [3:0] aluOp;
    branch_t    branchKind;
    logic       err;
    logic       accept;

    assign opcode = opcode_e'(instr[6:2]);
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    assign inReady = !uop.valid || uop.ready;  // single slot that streams when drained
    assign accept  = inValid && inReady;

    immGen immGenInst (
        .instr (instr),
        .fmt   (fmt),
        .imm   (immVal)
    );

    always_comb begin
        fmt        = IMM_I;
        bSrc       = BSRC_RS2;
        aluOp      = ALU_ADD;
        branchKind = BR_NONE;
        err        = 1'b0;
        case (opcode)
            LUI: begin
                fmt   = IMM_U;
                bSrc  = BSRC_IMM;
                aluOp = ALU_COPYB;
            end
            AUIPC: begin
                fmt  = IMM_U;
                bSrc = BSRC_IMM;
            end
            JAL: begin
                fmt        = IMM_J;
                bSrc       = BSRC_FOUR;
                branchKind = BR_JUMP;
            end
            JALR: begin
                bSrc       = BSRC_FOUR;
                branchKind = BR_JALR;
                err        = funct3 != 3'b000;
            end
            BRANCH: begin
                fmt   = IMM_B;
                aluOp = funct3[1] ? ALU_SLTU : ALU_SLT;  // bltu/bgeu compare unsigned
                case (funct3)
                    3'b000:           branchKind = BR_EQ;
                    3'b001:           branchKind = BR_NE;
                    3'b100, 3'b110:   branchKind = BR_LT;
                    3'b101, 3'b111:   branchKind = BR_GE;
                    default: begin
                        aluOp = ALU_ADD;
                        err   = 1'b1;
                    end
                endcase
            end
            LOAD: begin
                bSrc = BSRC_IMM;
                err  = funct3 == 3'b111;  // no ldu
            end
            STORE: begin
                fmt  = IMM_S;
                bSrc = BSRC_IMM;
                err  = funct3[2];
            end
            OPIMM: begin
                bSrc  = BSRC_IMM;
                aluOp = {funct7[5] && funct3 == 3'b101, funct3};
                err   = (funct3 == 3'b001 && funct7[6:1] != 6'b000000)
                     || (funct3 == 3'b101 && funct7[6:1] != 6'b000000
                                          && funct7[6:1] != 6'b010000);
            end
            OPIMM32: begin
                bSrc  = BSRC_IMM;
                aluOp = {funct7[5] && funct3 == 3'b101, funct3};
                err   = funct3 != 3'b000
                     && (funct3 != 3'b001 || funct7 != 7'b0000000)
                     && (funct3 != 3'b101 || (funct7 != 7'b0000000 && funct7 != 7'b0100000));
            end
            OP: begin
                aluOp = {funct7[5], funct3};
                err   = funct7 != 7'b0000000 && funct7 != 7'b0100000 && funct7 != 7'b0000001;
            end
            OP32: begin
                aluOp = {funct7[5], funct3};
                err   = ((funct7 != 7'b0000000 && funct7 != 7'b0100000)
                         || !(funct3 == 3'b000 || funct3 == 3'b001 || funct3 == 3'b101)
                         || (funct7 == 7'b0100000 && funct3 == 3'b001))
                     && (funct7 != 7'b0000001 || funct3 == 3'b001 || funct3 == 3'b010
                         || funct3 == 3'b011);
            end
            SYSTEM: begin
                bSrc       = BSRC_FOUR;
                branchKind = BR_JUMP;
                err        = instr != EBREAK;  // only ebreak is decoded
            end
            default: begin
                err = 1'b1;
            end
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            uop.valid <= 1'b0;
        end else if (accept) begin
            uop.valid <= 1'b1;
        end else if (uop.ready) begin
            uop.valid <= 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (accept) begin
            uop.imm      <= immVal;
            uop.rs1      <= instr[19:15];
            uop.rs2      <= instr[24:20];
            uop.rd       <= instr[11:7];
            uop.aluASrc  <= opcode == AUIPC || opcode == JAL || opcode == JALR;
            uop.aluBSrc  <= bSrc;
            uop.aluCtrl  <= {opcode == OP32 || (opcode == OP && funct7[0]), instr[3], aluOp};
            uop.branch   <= branchKind;
            uop.memRead  <= opcode == LOAD;
            uop.memWrite <= opcode == STORE;
            uop.memOp    <= funct3;
            uop.memToReg <= opcode == LOAD;
            uop.regWrite <= opcode != BRANCH && opcode != STORE;
            uop.illegal  <= err || instr[1:0] != 2'b11;
            uop.halt     <= instr == EBREAK;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/immGen.sv ====
`timescale 1ns/1ps
`default_nettype none

module immGen
    import rvIsaPkg::*;
    import uopPkg::*;
(
    input  wire instr_t  instr,
    input  wire immFmt_e fmt,
    output imm_t         imm
);

    localparam int XLen = $bits(imm_t);

    logic sign;

    assign sign = instr[31];  // every format takes its sign from bit 31

    always_comb begin
        case (fmt)
            IMM_S: begin
                imm = {{(XLen - 12){sign}}, instr[31:25], instr[11:7]};
            end
            IMM_B: begin
                imm = {{(XLen - 12){sign}}, instr[7], instr[30:25], instr[11:8], 1'b0};
            end
            IMM_J: begin
                imm = {{(XLen - 20){sign}}, instr[19:12], instr[20], instr[30:21], 1'b0};
            end
            IMM_U: begin
                imm = {{(XLen - 32){sign}}, instr[31:12], 12'b0};
            end
            default: begin  // I format
                imm = {{(XLen - 12){sign}}, instr[31:20]};
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== hdl/uopIf.sv ====
`timescale 1ns/1ps
`default_nettype none

interface uopIf import rvIsaPkg::*, uopPkg::*; ();

    logic     valid;
    logic     ready;
    imm_t     imm;
    regIdx_t  rs1;
    regIdx_t  rs2;
    regIdx_t  rd;
    logic     aluASrc;  // pc instead of rs1
    aluBSrc_t aluBSrc;
    aluCtrl_t aluCtrl;
    branch_t  branch;
    logic     memRead;
    logic     memWrite;
    memOp_t   memOp;
    logic     memToReg;
    logic     regWrite;
    logic     illegal;
    logic     halt;

    modport lane (
        output valid, imm, rs1, rs2, rd, aluASrc, aluBSrc, aluCtrl, branch,
        output memRead, memWrite, memOp, memToReg, regWrite, illegal, halt,
        input  ready
    );

    modport collector (
        input  valid, imm, rs1, rs2, rd, aluASrc, aluBSrc, aluCtrl, branch,
        input  memRead, memWrite, memOp, memToReg, regWrite, illegal, halt,
        output ready
    );

endinterface

`default_nettype wire

// ==== hdl/uopPkg.sv ====
`default_nettype none

`include "decode_cfg.svh"

package uopPkg;

    typedef logic [`DEC_XLEN-1:0] imm_t;
    typedef logic [5:0] aluCtrl_t;  // {word/mul, opcode[3], op}
    typedef logic [1:0] aluBSrc_t;
    typedef logic [2:0] branch_t;
    typedef logic [2:0] memOp_t;    // width and sign, same as funct3

    localparam aluBSrc_t BSRC_RS2  = 2'd0;
    localparam aluBSrc_t BSRC_FOUR = 2'd1;  // link address pc+4
    localparam aluBSrc_t BSRC_IMM  = 2'd2;

    localparam branch_t BR_NONE = 3'b000;
    localparam branch_t BR_JUMP = 3'b001;
    localparam branch_t BR_JALR = 3'b010;
    localparam branch_t BR_EQ   = 3'b100;
    localparam branch_t BR_NE   = 3'b101;
    localparam branch_t BR_LT   = 3'b110;
    localparam branch_t BR_GE   = 3'b111;

    // low nibble of aluCtrl
    localparam logic [3:0] ALU_ADD   = 4'b0000;
    localparam logic [3:0] ALU_SLT   = 4'b0010;
    localparam logic [3:0] ALU_SLTU  = 4'b0011;
    localparam logic [3:0] ALU_COPYB = 4'b1111;  // lui passes the immediate

endpackage

`default_nettype wire

// ==== hdl/rvIsaPkg.sv ====
`default_nettype none

package rvIsaPkg;

    typedef logic [31:0] instr_t;
    typedef logic [4:0]  regIdx_t;
    typedef logic [2:0]  funct3_t;
    typedef logic [6:0]  funct7_t;

    // opcode[6:2], low two bits are always 11
    typedef enum logic [4:0] {
        LOAD    = 5'b00000,
        OPIMM   = 5'b00100,
        AUIPC   = 5'b00101,
        OPIMM32 = 5'b00110,
        STORE   = 5'b01000,
        OP      = 5'b01100,
        LUI     = 5'b01101,
        OP32    = 5'b01110,
        BRANCH  = 5'b11000,
        JALR    = 5'b11001,
        JAL     = 5'b11011,
        SYSTEM  = 5'b11100
    } opcode_e;

    typedef enum logic [2:0] {
        IMM_I = 3'b000,
        IMM_J = 3'b001,
        IMM_S = 3'b010,
        IMM_B = 3'b011,
        IMM_U = 3'b101
    } immFmt_e;

    localparam instr_t EBREAK = 32'h00100073;

endpackage

`default_nettype wire

// ==== hdl/decode_cfg.svh ====
`ifndef DECODE_CFG_SVH
`define DECODE_CFG_SVH

// decode lanes per fetch packet, 1 to 4
`define DEC_LANES 2

// immediate and data width
`define DEC_XLEN 64

`endif
